/* tb.f */
+incdir+sim
source/rp_pkg.sv
source/sys_bus_decode.sv
source/hk_regs.sv
source/adc_front_end.sv
source/dac_mixer.sv
source/analog_top.sv
sim/analog_top_properties.sv
sim/tb_analog_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the analog_top testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module tb_analog_top -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sim/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  // both channels of a converted or looped back sample
  task automatic check_smp_pair(ch_pair_t got, ch_pair_t exp, string what);
    if (got !== exp)
    begin
      smp_errs++;
      $display("ERR @%0t: %s got a=%0d b=%0d, expected a=%0d b=%0d",
               $time, what, got.a, got.b, exp.a, exp.b);
    end
  endtask

  task automatic check_dac_pair(dac_pair_t got, dac_pair_t exp, string what);
    if (got !== exp)
    begin
      dac_errs++;
      $display("ERR @%0t: %s got a=%h b=%h, expected a=%h b=%h",
               $time, what, got.a, got.b, exp.a, exp.b);
    end
  endtask

  task automatic check_word(logic [BUS_DW-1:0] got, logic [BUS_DW-1:0] exp, string what);
    if (got !== exp)
    begin
      bus_errs++;
      $display("ERR @%0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ack and error flags of the bus
  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp)
    begin
      bus_errs++;
      $display("ERR @%0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

`endif

/* sim/tb_analog_top.sv */
`timescale 1ns/1ps

module tb_analog_top import rp_pkg::*;
();

  localparam int unsigned      SEED      = 32'haf84_ccd0;
  localparam int               HALF_T    = 5;    // 10 ns clock
  localparam int               ACK_LIMIT = 8;    // cycles per bus wait
  localparam int               N_STREAM  = 200;
  localparam logic [SMP_W-1:0] FLIP      = {1'b0, {(SMP_W-1){1'b1}}};

  logic          adc_clk;
  logic          arst_n_i;
  sys_bus_req_t  bus_req;
  sys_bus_rsp_t  bus_rsp;
  adc_raw_pair_t adc_dat;
  ch_pair_t      asg_dat;
  ch_pair_t      pid_dat;
  ch_pair_t      adc_out;
  dac_pair_t     dac_out;

  int smp_errs;
  int dac_errs;
  int bus_errs;
  int timeouts;

  // inputs of the previous cycle, what the registers hold now
  adc_raw_pair_t adc_prev;
  ch_pair_t      asg_prev;
  ch_pair_t      pid_prev;

  analog_top dut_i (
    .adc_clk   (adc_clk ),
    .arst_n_i  (arst_n_i),
    .bus_req_i (bus_req ),
    .bus_rsp_o (bus_rsp ),
    .adc_dat_i (adc_dat ),
    .asg_dat_i (asg_dat ),
    .pid_dat_i (pid_dat ),
    .adc_o     (adc_out ),
    .dac_dat_o (dac_out )
  );

  `include "tb_checks.svh"

  initial
  begin
    adc_clk = 1'b0;
    forever #HALF_T adc_clk = ~adc_clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic smp_t conv_model(adc_raw_t raw);
    logic [SMP_W-1:0] top;
    top = raw[ADC_IN_W-1:ADC_IN_W-SMP_W];  // two lsbs dropped
    return smp_t'(top ^ FLIP);
  endfunction

  function automatic smp_t sum_model(smp_t x, smp_t y);
    int s;
    int hi;
    hi = (1 << (SMP_W-1)) - 1;
    s  = int'(x) + int'(y);
    if (s > hi)
      s = hi;
    else if (s < -hi - 1)
      s = -hi - 1;
    return smp_t'(s);
  endfunction

  function automatic dac_code_t code_model(smp_t smp);
    return dac_code_t'(smp) ^ FLIP;
  endfunction

  // half of the draws sit at or near full scale
  function automatic smp_t rand_smp();
    logic [31:0] r;
    r = $urandom();
    case (r[2:0])
      3'd0    : return {1'b0, {(SMP_W-1){1'b1}}};  // +full scale
      3'd1    : return {1'b1, {(SMP_W-1){1'b0}}};  // -full scale
      3'd2    : return {2'b01, r[15:4]};
      3'd3    : return {2'b10, r[15:4]};
      default : return r[31:18];
    endcase
  endfunction

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  // n cycles of random samples, checked just before each rising edge
  task automatic stream(int n, logic loop_on);
    ch_pair_t    exp_smp;
    dac_pair_t   exp_dac;
    logic [31:0] r;
    for (int i = 0; i < n; i++)
    begin
      @(negedge adc_clk);
      adc_prev  = adc_dat;
      asg_prev  = asg_dat;
      pid_prev  = pid_dat;
      r         = $urandom();
      adc_dat.a = r[31:16];
      adc_dat.b = r[15:0];
      asg_dat.a = rand_smp();
      asg_dat.b = rand_smp();
      pid_dat.a = rand_smp();
      pid_dat.b = rand_smp();
      #(HALF_T-1);
      if (loop_on)
      begin
        exp_smp.a = sum_model(asg_dat.a, pid_dat.a);  // same cycle
        exp_smp.b = sum_model(asg_dat.b, pid_dat.b);
      end
      else
      begin
        exp_smp.a = conv_model(adc_prev.a);
        exp_smp.b = conv_model(adc_prev.b);
      end
      exp_dac.a = code_model(sum_model(asg_prev.a, pid_prev.a));
      exp_dac.b = code_model(sum_model(asg_prev.b, pid_prev.b));
      check_smp_pair(adc_out, exp_smp, loop_on ? "adc_o in loopback" : "adc_o");
      check_dac_pair(dac_out, exp_dac, "dac_dat_o");
    end
  endtask

  // one strobe, waits for ack and checks its timing
  task automatic bus_access(logic [BUS_AW-1:0] addr, logic wr, logic [BUS_DW-1:0] wdata,
                            output logic [BUS_DW-1:0] rdata);
    int   cycles;
    logic early_ack;
    logic hk_sel;
    hk_sel = (addr[REGION_LSB +: $bits(region_t)] == region_t'(HK_REGION));
    rdata  = '0;
    @(negedge adc_clk);
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    bus_req.sel   = 4'b0001;
    bus_req.wen   = wr;
    bus_req.ren   = !wr;
    #(HALF_T-1);
    early_ack = bus_rsp.ack;  // strobe cycle
    cycles    = 0;
    while (!bus_rsp.ack && cycles < ACK_LIMIT)
    begin
      @(negedge adc_clk);
      bus_req.wen = 1'b0;
      bus_req.ren = 1'b0;
      #(HALF_T-1);
      cycles++;
    end
    if (!bus_rsp.ack)
    begin
      $display("timeout: no bus ack within %0d cycles for address %h", ACK_LIMIT, addr);
      timeouts++;
    end
    else
    begin
      check_flag(early_ack, !hk_sel, "ack in strobe cycle");
      check_flag(cycles == 1, hk_sel, "ack one cycle after strobe");
      check_flag(bus_rsp.err, 1'b0, "bus error");
      rdata = bus_rsp.rdata;
    end
    @(negedge adc_clk);
    bus_req.wen = 1'b0;
    bus_req.ren = 1'b0;
  endtask

  task automatic read_expect(logic [BUS_AW-1:0] addr, logic [BUS_DW-1:0] exp, string what);
    logic [BUS_DW-1:0] rd;
    bus_access(addr, 1'b0, '0, rd);
    check_word(rd, exp, what);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    logic [BUS_DW-1:0] rd;
    logic [31:0]       r;
    dac_pair_t         mid;
    void'($urandom(SEED));
    smp_errs = 0;
    dac_errs = 0;
    bus_errs = 0;
    timeouts = 0;
    arst_n_i = 1'b0;
    bus_req  = '0;
    adc_dat  = '0;
    asg_dat  = '0;
    pid_dat  = '0;
    mid.a    = 14'h1FFF;  // code for zero
    mid.b    = 14'h1FFF;
    repeat (10) @(negedge adc_clk);
    arst_n_i = 1'b1;
    #(HALF_T-1);
    check_dac_pair(dac_out, mid, "dac_dat_o after reset");

    stream(N_STREAM, 1'b0);

    // housekeeping region
    read_expect(BUS_AW'(HK_OFS_ID), HK_ID_VALUE, "id word");
    bus_access(BUS_AW'(HK_OFS_LOOP), 1'b1, 32'h1, rd);
    read_expect(BUS_AW'(HK_OFS_LOOP), 32'h1, "loop bit set");
    for (int k = 0; k < 4; k++)
    begin
      r = $urandom();
      read_expect({12'h000, r[19:4], 4'h4}, '0, "unmapped offset");
    end

    stream(N_STREAM, 1'b1);

    // regions 1 to 7, writes must not reach the loop bit
    for (int g = 1; g < N_REGION; g++)
    begin
      r = $urandom();
      read_expect({9'h000, region_t'(g), r[19:0]}, '0, "unused region read");
      bus_access({9'h000, region_t'(g), HK_OFS_LOOP}, 1'b1, 32'h0, rd);
    end
    read_expect(BUS_AW'(HK_OFS_LOOP), 32'h1, "loop bit after unused writes");
    bus_access(BUS_AW'(HK_OFS_LOOP), 1'b1, 32'h0, rd);
    read_expect(BUS_AW'(HK_OFS_LOOP), 32'h0, "loop bit cleared");

    stream(N_STREAM, 1'b0);

    $display("errors: sample %0d, dac %0d, bus %0d, timeouts %0d",
             smp_errs, dac_errs, bus_errs, timeouts);
    if (smp_errs + dac_errs + bus_errs + timeouts == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim/analog_top_properties.sv */
`timescale 1ns/1ps

module analog_top_properties import rp_pkg::*;
(
  input logic          adc_clk,
  input logic          arst_n_i,
  input sys_bus_rsp_t  hk_rsp_i,   // housekeeping slave response
  input logic          loop_i,
  input adc_raw_pair_t adc_dat_i,
  input ch_pair_t      adc_smp_i,  // converted samples out of the top
  input dac_pair_t     dac_dat_i
);

  // top 14 bits, msb kept, lower 13 flipped
  function automatic ch_pair_t conv_raw_pair(adc_raw_pair_t raw);
    ch_pair_t c;
    c.a = {raw.a[ADC_IN_W-1], ~raw.a[ADC_IN_W-2 -: SMP_W-1]};
    c.b = {raw.b[ADC_IN_W-1], ~raw.b[ADC_IN_W-2 -: SMP_W-1]};
    return c;
  endfunction

  ack_one_cycle : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    hk_rsp_i.ack |-> !$past(hk_rsp_i.ack)
  ) else $error("housekeeping ack high in two cycles in a row");

  // adc register is one stage deep
  adc_path_delay : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
    (!loop_i && $past(arst_n_i)) |-> (adc_smp_i == conv_raw_pair($past(adc_dat_i)))
  ) else $error("adc_o does not match the previous raw adc word");

  dac_reset_code : assert property (
    @(posedge adc_clk)
    $rose(arst_n_i) |-> (dac_dat_i.a == 14'h1FFF && dac_dat_i.b == 14'h1FFF)
  ) else $error("dac code after reset is not mid scale");

endmodule

bind analog_top analog_top_properties u_props (
  .adc_clk   (adc_clk  ),
  .arst_n_i  (arst_n_i ),
  .hk_rsp_i  (hk_rsp   ),
  .loop_i    (loop     ),
  .adc_dat_i (adc_dat_i),
  .adc_smp_i (adc_o    ),
  .dac_dat_i (dac_dat_o)
);

/* source/analog_top.sv */
`timescale 1ns/1ps

module analog_top import rp_pkg::*;
(
  input  logic          adc_clk,
  input  logic          arst_n_i,
  // system bus
  input  sys_bus_req_t  bus_req_i,
  output sys_bus_rsp_t  bus_rsp_o,
  // adc
  input  adc_raw_pair_t adc_dat_i,
  // generator and controller samples
  input  ch_pair_t      asg_dat_i,
  input  ch_pair_t      pid_dat_i,
  // channel outputs
  output ch_pair_t      adc_o,      // converted samples
  output dac_pair_t     dac_dat_o   // dac codes
);

  sys_bus_req_t hk_req;    // region 0 request
  sys_bus_rsp_t hk_rsp;
  logic         loop;      // digital loopback
  ch_pair_t     dac_smp;   // saturated sum

  //////////////////////////////
  // bus decode
  //////////////////////////////

  sys_bus_decode u_decode (
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .hk_req_o  (hk_req   ),
    .hk_rsp_i  (hk_rsp   )
  );

  //////////////////////////////
  // housekeeping
  //////////////////////////////

  hk_regs u_hk (
    .adc_clk  (adc_clk ),
    .arst_n_i (arst_n_i),
    .req_i    (hk_req  ),
    .rsp_o    (hk_rsp  ),
    .loop_o   (loop    )   // to the adc front end
  );

  //////////////////////////////
  // channel datapath
  //////////////////////////////

  adc_front_end u_adc (
    .adc_clk   (adc_clk  ),
    .arst_n_i  (arst_n_i ),
    .adc_dat_i (adc_dat_i),
    .loop_i    (loop     ),
    .dac_smp_i (dac_smp  ),
    .adc_o     (adc_o    )
  );

  //////////////////////////////
  // dac output stage
  //////////////////////////////

  dac_mixer u_dac (
    .adc_clk   (adc_clk  ),
    .arst_n_i  (arst_n_i ),
    .asg_dat_i (asg_dat_i),
    .pid_dat_i (pid_dat_i),
    .dac_smp_o (dac_smp  ),  // loopback source
    .dac_dat_o (dac_dat_o)
  );

endmodule

/* source/dac_mixer.sv */
`timescale 1ns/1ps

module dac_mixer import rp_pkg::*;
(
  input  logic      adc_clk,
  input  logic      arst_n_i,
  input  ch_pair_t  asg_dat_i,  // generator samples
  input  ch_pair_t  pid_dat_i,  // controller samples
  output ch_pair_t  dac_smp_o,  // saturated sum, combinational
  output dac_pair_t dac_dat_o   // registered dac codes
);

  //////////////////////////////
  // helpers
  //////////////////////////////

  // 15 bit add, clamp when the two top bits disagree
  function automatic smp_t sat_add(smp_t x, smp_t y);
    logic signed [SUM_W-1:0] s;
    s = SUM_W'(x) + SUM_W'(y);
    if (s[SUM_W-1] ^ s[SUM_W-2])
      return {s[SUM_W-1], {(SMP_W-1){~s[SUM_W-1]}}};  // full scale, sign of sum
    return s[SMP_W-1:0];
  endfunction

  // signed to unsigned negative slope
  function automatic dac_code_t to_code(smp_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

  ch_pair_t  sat;
  dac_pair_t code_q;

  assign sat.a = sat_add(asg_dat_i.a, pid_dat_i.a);
  assign sat.b = sat_add(asg_dat_i.b, pid_dat_i.b);

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      code_q.a <= to_code('0);  // mid scale, 0x1fff
      code_q.b <= to_code('0);
    end
    else
    begin
      code_q.a <= to_code(sat.a);
      code_q.b <= to_code(sat.b);
    end
  end

  assign dac_smp_o = sat;     // feeds the loopback mux
  assign dac_dat_o = code_q;  // both channels in parallel

endmodule

/* source/adc_front_end.sv */
`timescale 1ns/1ps

module adc_front_end import rp_pkg::*;
(
  input  logic          adc_clk,
  input  logic          arst_n_i,
  input  adc_raw_pair_t adc_dat_i,  // raw converter words
  input  logic          loop_i,     // from housekeeping
  input  ch_pair_t      dac_smp_i,  // saturated dac samples for loopback
  output ch_pair_t      adc_o
);

  logic [SMP_W-1:0] raw_a_q;  // top 14 bits of channel a
  logic [SMP_W-1:0] raw_b_q;
  ch_pair_t         conv;

  //////////////////////////////
  // input register
  //////////////////////////////

  // two low bits are kept free for a 16 bit converter
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end
    else
    begin
      raw_a_q <= adc_dat_i.a[ADC_IN_W-1 -: SMP_W];
      raw_b_q <= adc_dat_i.b[ADC_IN_W-1 -: SMP_W];
    end
  end

  //////////////////////////////
  // negative slope to 2's complement
  //////////////////////////////

  assign conv.a = {raw_a_q[SMP_W-1], ~raw_a_q[SMP_W-2:0]};  // msb kept, rest flipped
  assign conv.b = {raw_b_q[SMP_W-1], ~raw_b_q[SMP_W-2:0]};

  // loopback replaces both channels, no register on that path
  assign adc_o = loop_i ? dac_smp_i : conv;

endmodule

/* source/hk_regs.sv */
`timescale 1ns/1ps

module hk_regs import rp_pkg::*;
(
  input  logic         adc_clk,
  input  logic         arst_n_i,
  input  sys_bus_req_t req_i,     // strobes already gated by the decoder
  output sys_bus_rsp_t rsp_o,
  output logic         loop_o     // digital loopback enable
);

  logic [REGION_LSB-1:0] ofs;      // offset inside the region
  logic [BUS_DW-1:0]     rd_word;  // read mux output
  logic [BUS_DW-1:0]     rdata_q;
  logic                  ack_q;
  logic                  loop_q;

  assign ofs = req_i.addr[REGION_LSB-1:0];

  //////////////////////////////
  // control state
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q  <= 1'b0;
      loop_q <= 1'b0;  // loopback off after reset
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;  // one cycle after any strobe
      // only byte lane 0 carries the loop bit
      if (req_i.wen && (ofs == HK_OFS_LOOP) && req_i.sel[0])
      begin
        loop_q <= req_i.wdata[0];
      end
    end
  end

  //////////////////////////////
  // read path
  //////////////////////////////

  always_comb
  begin
    case (ofs)
      HK_OFS_ID   : rd_word = HK_ID_VALUE;
      HK_OFS_LOOP : rd_word = {{(BUS_DW-1){1'b0}}, loop_q};
      default     : rd_word = '0;  // unmapped offsets read zero
    endcase
  end

  // captured with the read strobe, valid with ack
  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren)
    begin
      rdata_q <= rd_word;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.ack   = ack_q;
  assign loop_o      = loop_q;

endmodule

/* source/sys_bus_decode.sv */
`timescale 1ns/1ps

module sys_bus_decode import rp_pkg::*;
(
  input  sys_bus_req_t bus_req_i,  // from the bus master
  output sys_bus_rsp_t bus_rsp_o,  // back to the bus master
  output sys_bus_req_t hk_req_o,   // housekeeping slave port
  input  sys_bus_rsp_t hk_rsp_i
);

  //////////////////////////////
  // region select
  //////////////////////////////

  region_t               region;
  logic   [N_REGION-1:0] cs;           // one hot chip select
  sys_bus_rsp_t          rsp [N_REGION];

  // upper address bits pick one of eight regions
  assign region = bus_req_i.addr[REGION_LSB +: $bits(region_t)];
  assign cs     = N_REGION'(1) << region;

  //////////////////////////////
  // request to the slaves
  //////////////////////////////

  // address, data and byte select fan out unchanged,
  // only the strobes are qualified by the select
  always_comb
  begin
    hk_req_o     = bus_req_i;
    hk_req_o.wen = bus_req_i.wen & cs[HK_REGION];  // gated write strobe
    hk_req_o.ren = bus_req_i.ren & cs[HK_REGION];  // gated read strobe
  end

  //////////////////////////////
  // response collection
  //////////////////////////////

  for (genvar g = 0; g < N_REGION; g++)
  begin : g_region
    if (g == HK_REGION)
    begin : g_hk
      assign rsp[g] = hk_rsp_i;  // real slave
    end
    else
    begin : g_unused
      // empty region, answers at once with zero data
      assign rsp[g].rdata = '0;
      assign rsp[g].err   = 1'b0;
      assign rsp[g].ack   = 1'b1;  // ack also in the strobe cycle
    end
  end

  // response of the addressed region only
  always_comb
  begin
    bus_rsp_o.rdata = rsp[region].rdata;
    bus_rsp_o.err   = rsp[region].err;
    bus_rsp_o.ack   = rsp[region].ack;
  end

endmodule

/* source/rp_pkg.sv */
package rp_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int unsigned ADC_IN_W  = 16;  // raw converter word
  localparam int unsigned SMP_W     = 14;  // two's complement sample
  localparam int unsigned SUM_W     = 15;  // one guard bit for the adder
  localparam int unsigned BUS_AW    = 32;
  localparam int unsigned BUS_DW    = 32;
  localparam int unsigned BUS_SEL_W = 4;   // one bit per byte lane

  //////////////////////////////
  // address map
  //////////////////////////////

  localparam int unsigned N_REGION   = 8;
  localparam int unsigned REGION_LSB = 20;  // region field is addr[22:20]
  localparam int unsigned HK_REGION  = 0;

  // housekeeping offsets, relative to the region base
  localparam logic [REGION_LSB-1:0] HK_OFS_ID   = REGION_LSB'('h00);
  localparam logic [REGION_LSB-1:0] HK_OFS_LOOP = REGION_LSB'('h0C);
  localparam logic [BUS_DW-1:0]     HK_ID_VALUE = 32'h5250_0a17;

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic        [ADC_IN_W-1:0] adc_raw_t;   // unsigned, negative slope
  typedef logic signed [SMP_W-1:0]    smp_t;
  typedef logic        [SMP_W-1:0]    dac_code_t;  // unsigned, negative slope

  typedef logic [$clog2(N_REGION)-1:0] region_t;

  typedef struct packed {
    adc_raw_t a;
    adc_raw_t b;
  } adc_raw_pair_t;

  // adc, generator and pid samples all travel this way
  typedef struct packed {
    smp_t a;
    smp_t b;
  } ch_pair_t;

  typedef struct packed {
    dac_code_t a;
    dac_code_t b;
  } dac_pair_t;

  typedef struct packed {
    logic [BUS_AW-1:0]    addr;   // held until ack
    logic [BUS_DW-1:0]    wdata;
    logic [BUS_SEL_W-1:0] sel;    // write byte select
    logic                 wen;    // single cycle pulse
    logic                 ren;    // single cycle pulse
  } sys_bus_req_t;

  typedef struct packed {
    logic [BUS_DW-1:0] rdata;
    logic              err;
    logic              ack;
  } sys_bus_rsp_t;

endpackage
